// ==== src/im2col_pkg.sv ====
package im2col_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sizes

    localparam int DATA_W      = 8;
    localparam int DIM_W       = 8;
    localparam int VOL_W       = 2 * DIM_W;
    // Wide enough for any address product before it is cut down
    localparam int CALC_W      = 3 * DIM_W;
    localparam int IMG_DEPTH   = 64;
    localparam int COL_DEPTH   = 128;
    localparam int IMG_ADDR_W  = $clog2(IMG_DEPTH);
    localparam int COL_ADDR_W  = $clog2(COL_DEPTH);
    localparam int RAM_LATENCY = 1;

    ////////////////////////////////////////////////////////////////////////////
    // Types

    // Pooling code is reserved and behaves as NOP
    typedef enum logic [1:0] {
        MODE_NOP  = 2'b00,
        MODE_POOL = 2'b01,
        MODE_MVM  = 2'b10,
        MODE_CONV = 2'b11
    } op_mode_e;

    typedef struct packed {
        op_mode_e         mode;
        logic [DIM_W-1:0] image_width;
        logic [DIM_W-1:0] image_height;
        logic [DIM_W-1:0] image_channel;
        logic [DIM_W-1:0] filter_width;
        logic [DIM_W-1:0] filter_height;
        logic [DIM_W-1:0] slice_width;
        logic [DIM_W-1:0] slice_height;
        logic [DIM_W-1:0] slice_number;
    } im2col_cfg_t;

    // Latched configuration plus derived sizes
    typedef struct packed {
        im2col_cfg_t      cfg;
        logic [DIM_W-1:0] patch_width;
        logic [DIM_W-1:0] patch_height;
        logic [VOL_W-1:0] filter_volume;
        logic [VOL_W-1:0] pixel_count;
    } im2col_geom_t;

    typedef struct packed {
        logic                     valid;
        logic [COL_ADDR_W-1:0]    addr;
        logic signed [DATA_W-1:0] data;
    } col_wr_t;

endpackage

// ==== src/im2col_param_regs.sv ====
`timescale 1ns/10ps

module im2col_param_regs
    import im2col_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_n_reset,
    input  logic         i_set_param,
    input  logic         i_terminate,
    input  im2col_cfg_t  i_cfg,
    output im2col_geom_t o_geom,
    output logic         o_set_param_done
);

    im2col_cfg_t      cfg_q;
    logic [DIM_W-1:0] patch_width_q;
    logic [DIM_W-1:0] patch_height_q;
    logic [VOL_W-1:0] filter_volume_q;
    logic [VOL_W-1:0] pixel_count_q;
    logic [2:0]       done_sr;
    logic             conv_mode;

    assign conv_mode = (cfg_q.mode == MODE_CONV);

    ////////////////////////////////////////////////////////////////////////////
    // Configuration latch

    always_ff @(posedge i_clk) begin
        if (!i_n_reset) begin
            cfg_q <= '0;
        end else if (i_set_param) begin
            cfg_q <= i_cfg;
        end else if (i_terminate) begin
            cfg_q <= '0;
        end
    end

    // Derived sizes one stage behind the latch
    always_ff @(posedge i_clk) begin
        if (!i_n_reset) begin
            patch_width_q   <= '0;
            patch_height_q  <= '0;
            filter_volume_q <= '0;
            pixel_count_q   <= '0;
        end else begin
            patch_width_q   <= (conv_mode && cfg_q.image_width != '0) ?
                               cfg_q.image_width - cfg_q.filter_width + 1'b1 : '0;
            patch_height_q  <= (conv_mode && cfg_q.image_height != '0) ?
                               cfg_q.image_height - cfg_q.filter_height + 1'b1 : '0;
            filter_volume_q <= cfg_q.image_channel * cfg_q.filter_width * cfg_q.filter_height;
            pixel_count_q   <= cfg_q.image_channel * cfg_q.image_height * cfg_q.image_width;
        end
    end

    // Done strobe three cycles after the request
    always_ff @(posedge i_clk) begin
        if (!i_n_reset) begin
            done_sr <= '0;
        end else begin
            done_sr <= {done_sr[1:0], i_set_param};
        end
    end

    always_comb begin
        o_geom.cfg           = cfg_q;
        o_geom.patch_width   = patch_width_q;
        o_geom.patch_height  = patch_height_q;
        o_geom.filter_volume = filter_volume_q;
        o_geom.pixel_count   = pixel_count_q;
    end

    assign o_set_param_done = done_sr[2];

endmodule

// ==== src/im2col_addr_gen.sv ====
`timescale 1ns/10ps

module im2col_addr_gen
    import im2col_pkg::*;
(
    input  logic                     i_clk,
    input  logic                     i_n_reset,
    input  logic                     i_set_param,
    input  logic                     i_terminate,
    input  logic                     i_enable,
    input  im2col_geom_t             i_geom,
    input  logic signed [DATA_W-1:0] i_data,
    input  logic                     i_valid,
    output logic [IMG_ADDR_W-1:0]    o_im2col_address,
    output col_wr_t                  o_col_wr,
    output logic                     o_convert_done
);

    logic [DIM_W-1:0]      fc_cnt;
    logic [DIM_W-1:0]      fr_cnt;
    logic [DIM_W-1:0]      pc_cnt;
    logic [DIM_W-1:0]      pr_cnt;
    logic [DIM_W-1:0]      ch_cnt;
    logic [IMG_ADDR_W-1:0] lin_cnt;
    logic [COL_ADDR_W-1:0] pix_cnt;
    logic                  issue_done;
    logic                  pix_done;
    logic [1:0]            done_dly;
    logic                  conv_mode;
    logic                  mvm_mode;
    logic                  step;
    logic                  wr_en;
    logic                  fc_last;
    logic                  fr_last;
    logic                  pc_last;
    logic                  pr_last;
    logic                  ch_last;
    logic [CALC_W-1:0]     filter_area;
    logic [CALC_W-1:0]     src_full;
    logic [CALC_W-1:0]     col_full;
    logic [RAM_LATENCY:0]  step_pipe;
    logic [COL_ADDR_W-1:0] col_addr_pipe [RAM_LATENCY+1];

    assign conv_mode = (i_geom.cfg.mode == MODE_CONV);
    assign mvm_mode  = (i_geom.cfg.mode == MODE_MVM);
    assign step      = i_enable && !issue_done && (conv_mode || mvm_mode);

    assign fc_last = (fc_cnt == i_geom.cfg.filter_width - 1'b1);
    assign fr_last = (fr_cnt == i_geom.cfg.filter_height - 1'b1);
    assign pc_last = (pc_cnt == i_geom.patch_width - 1'b1);
    assign pr_last = (pr_cnt == i_geom.patch_height - 1'b1);
    assign ch_last = (ch_cnt == i_geom.cfg.image_channel - 1'b1);

    ////////////////////////////////////////////////////////////////////////////
    // Address arithmetic

    assign filter_area = i_geom.cfg.filter_width * i_geom.cfg.filter_height;
    assign src_full = conv_mode ?
        (ch_cnt * i_geom.cfg.image_height + fr_cnt + pr_cnt) * i_geom.cfg.image_width
        + fc_cnt + pc_cnt : CALC_W'(lin_cnt);
    assign col_full = (pr_cnt * i_geom.patch_width + pc_cnt) * i_geom.filter_volume
        + ch_cnt * filter_area + fr_cnt * i_geom.cfg.filter_width + fc_cnt;

    // Five nested loops with filter column innermost
    always_ff @(posedge i_clk) begin
        if (!i_n_reset || i_set_param || i_terminate) begin
            fc_cnt           <= '0;
            fr_cnt           <= '0;
            pc_cnt           <= '0;
            pr_cnt           <= '0;
            ch_cnt           <= '0;
            lin_cnt          <= '0;
            issue_done       <= 1'b0;
            o_im2col_address <= '0;
        end else if (step) begin
            o_im2col_address <= src_full[IMG_ADDR_W-1:0];
            if (mvm_mode) begin
                lin_cnt    <= lin_cnt + 1'b1;
                issue_done <= (lin_cnt == i_geom.pixel_count - 1'b1);
            end else begin
                fc_cnt <= fc_last ? '0 : fc_cnt + 1'b1;
                if (fc_last) begin
                    fr_cnt <= fr_last ? '0 : fr_cnt + 1'b1;
                    if (fr_last) begin
                        pc_cnt <= pc_last ? '0 : pc_cnt + 1'b1;
                        if (pc_last) begin
                            pr_cnt <= pr_last ? '0 : pr_cnt + 1'b1;
                            if (pr_last) begin
                                ch_cnt <= ch_last ? '0 : ch_cnt + 1'b1;
                            end
                        end
                    end
                end
                issue_done <= fc_last && fr_last && pc_last && pr_last && ch_last;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Buffer address follows the RAM latency

    always_ff @(posedge i_clk) begin
        if (!i_n_reset || i_set_param || i_terminate) begin
            step_pipe <= '0;
            pix_cnt   <= '0;
            pix_done  <= 1'b0;
            done_dly  <= '0;
        end else begin
            step_pipe <= {step_pipe[RAM_LATENCY-1:0], step};
            done_dly  <= {done_dly[0], issue_done};
            if (mvm_mode && wr_en && !pix_done) begin
                pix_cnt  <= pix_cnt + 1'b1;
                pix_done <= (pix_cnt == i_geom.pixel_count - 1'b1);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        col_addr_pipe[0] <= col_full[COL_ADDR_W-1:0];
        for (int i = 1; i <= RAM_LATENCY; i++) begin
            col_addr_pipe[i] <= col_addr_pipe[i-1];
        end
    end

    assign wr_en = step_pipe[RAM_LATENCY] && i_valid;

    always_comb begin
        o_col_wr.valid = wr_en;
        o_col_wr.addr  = mvm_mode ? pix_cnt : col_addr_pipe[RAM_LATENCY];
        o_col_wr.data  = i_data;
    end

    assign o_convert_done = conv_mode ? done_dly[1] : (mvm_mode && pix_done);

    // Column matrix has to fit the buffer
    assert property (@(posedge i_clk) disable iff (!i_n_reset)
        step && conv_mode |-> col_full < COL_DEPTH)
        else $error("column address %0d beyond buffer", col_full);

endmodule

// ==== src/im2col_col_buffer.sv ====
`timescale 1ns/10ps

module im2col_col_buffer
    import im2col_pkg::*;
(
    input  logic                     i_clk,
    input  logic                     i_n_reset,
    input  logic                     i_clear,
    input  col_wr_t                  i_col_wr,
    input  logic [COL_ADDR_W-1:0]    i_rd_addr,
    output logic signed [DATA_W-1:0] o_rd_data
);

    logic signed [DATA_W-1:0] mem [COL_DEPTH];

    ////////////////////////////////////////////////////////////////////////////
    // Storage

    // Whole buffer is wiped before each new conversion
    always_ff @(posedge i_clk) begin
        if (!i_n_reset || i_clear) begin
            for (int i = 0; i < COL_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (i_col_wr.valid) begin
            mem[i_col_wr.addr] <= i_col_wr.data;
        end
    end

    // Read side is asynchronous
    assign o_rd_data = mem[i_rd_addr];

endmodule

// ==== src/im2col_slice_reader.sv ====
`timescale 1ns/10ps

module im2col_slice_reader
    import im2col_pkg::*;
(
    input  logic                     i_clk,
    input  logic                     i_n_reset,
    input  logic                     i_set_param,
    input  logic                     i_terminate,
    input  logic                     i_read,
    input  im2col_geom_t             i_geom,
    input  logic signed [DATA_W-1:0] i_rd_data,
    output logic [COL_ADDR_W-1:0]    o_rd_addr,
    output logic signed [DATA_W-1:0] o_data,
    output logic                     o_valid,
    output logic                     o_slice_read_done,
    output logic                     o_slice_last
);

    logic [DIM_W-1:0]         col_cnt;
    logic [DIM_W-1:0]         row_cnt;
    logic [DIM_W-1:0]         idx_cnt;
    logic                     read_done_q;
    logic                     last_q;
    logic                     valid_q;
    logic signed [DATA_W-1:0] data_q;
    logic                     advance;
    logic                     col_last;
    logic                     row_last;
    logic                     idx_last;
    logic [CALC_W-1:0]        rd_addr_full;

    assign advance  = i_read && !read_done_q && !last_q;
    assign col_last = (col_cnt >= i_geom.cfg.slice_width - 1'b1);
    assign row_last = (row_cnt >= i_geom.cfg.slice_height - 1'b1);
    assign idx_last = (idx_cnt >= i_geom.cfg.slice_number - 1'b1);

    assign rd_addr_full = idx_cnt * i_geom.cfg.slice_height * i_geom.cfg.slice_width
                        + row_cnt * i_geom.cfg.slice_width + col_cnt;
    assign o_rd_addr    = rd_addr_full[COL_ADDR_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Slice walk

    // Slice index survives a dropped read request
    always_ff @(posedge i_clk) begin
        if (!i_n_reset || i_set_param || i_terminate) begin
            col_cnt     <= '0;
            row_cnt     <= '0;
            idx_cnt     <= '0;
            read_done_q <= 1'b0;
            last_q      <= 1'b0;
        end else if (advance) begin
            col_cnt <= col_last ? '0 : col_cnt + 1'b1;
            if (col_last) begin
                row_cnt <= row_last ? '0 : row_cnt + 1'b1;
                if (row_last) begin
                    idx_cnt <= idx_last ? '0 : idx_cnt + 1'b1;
                    last_q  <= idx_last;
                end
            end
            read_done_q <= col_last && row_last;
        end else begin
            col_cnt     <= '0;
            row_cnt     <= '0;
            read_done_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_n_reset || i_set_param || i_terminate) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= advance;
        end
    end

    always_ff @(posedge i_clk) begin
        if (advance) begin
            data_q <= i_rd_data;
        end
    end

    assign o_data            = data_q;
    assign o_valid           = valid_q;
    assign o_slice_read_done = read_done_q;
    assign o_slice_last      = last_q;

    // Nothing comes out once the final slice is done
    assert property (@(posedge i_clk) disable iff (!i_n_reset)
        o_slice_last |=> !o_valid)
        else $error("output valid after last slice");

endmodule

// ==== src/im2col_top.sv ====
`timescale 1ns/10ps

module im2col_top
    import im2col_pkg::*;
(
    input  logic                     i_clk,
    input  logic                     i_n_reset,
    input  logic                     i_set_param,
    input  im2col_cfg_t              i_cfg,
    input  logic                     i_terminate,
    input  logic                     i_enable,
    input  logic                     i_read,
    input  logic signed [DATA_W-1:0] i_data,
    input  logic                     i_valid,
    output logic [IMG_ADDR_W-1:0]    o_im2col_address,
    output logic                     o_set_param_done,
    output logic                     o_convert_done,
    output logic signed [DATA_W-1:0] o_data,
    output logic                     o_valid,
    output logic                     o_slice_read_done,
    output logic                     o_slice_last
);

    im2col_geom_t             geom;
    col_wr_t                  col_wr;
    logic [COL_ADDR_W-1:0]    rd_addr;
    logic signed [DATA_W-1:0] rd_data;

    im2col_param_regs im2col_param_regs_inst (
        .i_clk            (i_clk),
        .i_n_reset        (i_n_reset),
        .i_set_param      (i_set_param),
        .i_terminate      (i_terminate),
        .i_cfg            (i_cfg),
        .o_geom           (geom),
        .o_set_param_done (o_set_param_done)
    );

    im2col_addr_gen im2col_addr_gen_inst (
        .i_clk            (i_clk),
        .i_n_reset        (i_n_reset),
        .i_set_param      (i_set_param),
        .i_terminate      (i_terminate),
        .i_enable         (i_enable),
        .i_geom           (geom),
        .i_data           (i_data),
        .i_valid          (i_valid),
        .o_im2col_address (o_im2col_address),
        .o_col_wr         (col_wr),
        .o_convert_done   (o_convert_done)
    );

    im2col_col_buffer im2col_col_buffer_inst (
        .i_clk     (i_clk),
        .i_n_reset (i_n_reset),
        .i_clear   (i_set_param | i_terminate),
        .i_col_wr  (col_wr),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    im2col_slice_reader im2col_slice_reader_inst (
        .i_clk             (i_clk),
        .i_n_reset         (i_n_reset),
        .i_set_param       (i_set_param),
        .i_terminate       (i_terminate),
        .i_read            (i_read),
        .i_geom            (geom),
        .i_rd_data         (rd_data),
        .o_rd_addr         (rd_addr),
        .o_data            (o_data),
        .o_valid           (o_valid),
        .o_slice_read_done (o_slice_read_done),
        .o_slice_last      (o_slice_last)
    );

endmodule

// ==== tb/im2col_tb.sv ====
`timescale 1ns/10ps

module im2col_tb
    import im2col_pkg::*;
();

    localparam logic [31:0] SEED     = 32'h7d85_ff53;
    localparam int SLICE_LEN         = 8;
    localparam int DONE_TIMEOUT      = 20;
    localparam int READ_TIMEOUT      = 400;

    logic                     i_clk = 1'b0;
    logic                     i_n_reset;
    logic                     i_set_param;
    im2col_cfg_t              i_cfg;
    logic                     i_terminate;
    logic                     i_enable;
    logic                     i_read;
    logic signed [DATA_W-1:0] i_data;
    logic                     i_valid;
    logic [IMG_ADDR_W-1:0]    o_im2col_address;
    logic                     o_set_param_done;
    logic                     o_convert_done;
    logic signed [DATA_W-1:0] o_data;
    logic                     o_valid;
    logic                     o_slice_read_done;
    logic                     o_slice_last;

    logic signed [DATA_W-1:0] image [IMG_DEPTH];
    logic signed [DATA_W-1:0] col_ref [COL_DEPTH];
    int                       exp_addr [$];
    logic [IMG_ADDR_W-1:0]    addr_q = '0;
    logic [1:0]               en_hist = '0;
    int                       valid_seen = 0;
    int                       error_count = 0;
    int                       timeout_count = 0;
    im2col_cfg_t              conv_cfg;
    im2col_cfg_t              mvm_cfg;

    always #50 i_clk = ~i_clk;

    im2col_top im2col_top_inst (
        .i_clk             (i_clk),
        .i_n_reset         (i_n_reset),
        .i_set_param       (i_set_param),
        .i_cfg             (i_cfg),
        .i_terminate       (i_terminate),
        .i_enable          (i_enable),
        .i_read            (i_read),
        .i_data            (i_data),
        .i_valid           (i_valid),
        .o_im2col_address  (o_im2col_address),
        .o_set_param_done  (o_set_param_done),
        .o_convert_done    (o_convert_done),
        .o_data            (o_data),
        .o_valid           (o_valid),
        .o_slice_read_done (o_slice_read_done),
        .o_slice_last      (o_slice_last)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    task automatic flag_error(input string msg);
        error_count++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    task automatic note_timeout(input string what);
        timeout_count++;
        $display("Timed out waiting for %s at %0t ns", what, $time);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic im2col_cfg_t make_cfg(input op_mode_e mode, input int w, input int h,
                                             input int ch, input int fw, input int fh,
                                             input int sw, input int sh, input int sn);
        im2col_cfg_t c;
        c.mode          = mode;
        c.image_width   = DIM_W'(w);
        c.image_height  = DIM_W'(h);
        c.image_channel = DIM_W'(ch);
        c.filter_width  = DIM_W'(fw);
        c.filter_height = DIM_W'(fh);
        c.slice_width   = DIM_W'(sw);
        c.slice_height  = DIM_W'(sh);
        c.slice_number  = DIM_W'(sn);
        return c;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Image RAM model with one cycle from address to data

    always @(posedge i_clk) begin
        addr_q  <= o_im2col_address;
        en_hist <= {en_hist[0], i_enable};
        if (i_valid) begin
            valid_seen <= valid_seen + 1;
        end
    end

    always @(negedge i_clk) begin
        i_data  = image[addr_q];
        i_valid = en_hist[1];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model

    // Source addresses in counter order and the expected column matrix
    task automatic build_reference(input im2col_cfg_t cfg);
        int w;
        int h;
        int chn;
        int fw;
        int fh;
        int pw;
        int ph;
        int fv;
        int src;
        int col;
        w   = cfg.image_width;
        h   = cfg.image_height;
        chn = cfg.image_channel;
        fw  = cfg.filter_width;
        fh  = cfg.filter_height;
        pw  = w - fw + 1;
        ph  = h - fh + 1;
        fv  = chn * fw * fh;
        exp_addr.delete();
        for (int i = 0; i < COL_DEPTH; i++) begin
            col_ref[i] = '0;
        end
        if (cfg.mode == MODE_MVM) begin
            for (int i = 0; i < chn * h * w; i++) begin
                exp_addr.push_back(i);
                col_ref[i] = image[i];
            end
        end else begin
            for (int ch = 0; ch < chn; ch++)
            for (int pr = 0; pr < ph; pr++)
            for (int pc = 0; pc < pw; pc++)
            for (int fr = 0; fr < fh; fr++)
            for (int fc = 0; fc < fw; fc++) begin
                src = (ch * h + fr + pr) * w + fc + pc;
                col = (pr * pw + pc) * fv + ch * fw * fh + fr * fw + fc;
                exp_addr.push_back(src);
                col_ref[col] = image[src];
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus tasks enter and leave on a falling edge

    task automatic configure(input im2col_cfg_t cfg);
        int waited;
        i_cfg       = cfg;
        i_set_param = 1'b1;
        @(negedge i_clk);
        i_set_param = 1'b0;
        waited = 1;
        while (!o_set_param_done && waited < DONE_TIMEOUT) begin
            @(negedge i_clk);
            waited++;
        end
        if (!o_set_param_done) begin
            note_timeout("set_param_done");
        end else begin
            assert (waited == 3)
                else flag_error($sformatf("set_param_done after %0d cycles", waited));
        end
        @(negedge i_clk);
        assert (!o_set_param_done) else flag_error("set_param_done wider than one cycle");
    endtask

    task automatic convert(input string what);
        int base;
        int waited;
        base     = valid_seen;
        i_enable = 1'b1;
        foreach (exp_addr[k]) begin
            @(negedge i_clk);
            assert (int'(o_im2col_address) == exp_addr[k])
                else flag_error($sformatf("%s step %0d address %0d, expected %0d",
                                          what, k, o_im2col_address, exp_addr[k]));
            assert (!o_convert_done) else flag_error($sformatf("%s done too early", what));
        end
        waited = 0;
        while (!o_convert_done && waited < DONE_TIMEOUT) begin
            @(negedge i_clk);
            waited++;
        end
        i_enable = 1'b0;
        if (!o_convert_done) begin
            note_timeout({what, " convert_done"});
        end else begin
            assert (waited == 2)
                else flag_error($sformatf("%s done %0d cycles late", what, waited - 2));
            assert (valid_seen - base == exp_addr.size())
                else flag_error($sformatf("%s done after %0d valid pixels",
                                          what, valid_seen - base));
        end
    endtask

    // Optional drop of the read request inside one slice
    task automatic read_out(input int n_slices, input int drop_slice, input int drop_pos);
        int slice;
        int pos;
        int guard;
        bit dropped;
        slice   = 0;
        pos     = 0;
        guard   = 0;
        dropped = 1'b0;
        i_read  = 1'b1;
        do begin
            @(negedge i_clk);
            guard++;
            if (o_valid) begin
                assert (o_data === col_ref[slice * SLICE_LEN + pos])
                    else flag_error($sformatf("slice %0d element %0d is %0d, expected %0d",
                                              slice, pos, o_data,
                                              col_ref[slice * SLICE_LEN + pos]));
                pos++;
            end
            if (o_slice_read_done) begin
                assert (pos == SLICE_LEN)
                    else flag_error($sformatf("slice %0d done after %0d outputs", slice, pos));
                slice++;
                pos = 0;
            end
            if (!dropped && slice == drop_slice && pos == drop_pos) begin
                dropped = 1'b1;
                i_read  = 1'b0;
                repeat (3) begin
                    @(negedge i_clk);
                    assert (!o_valid) else flag_error("valid while read is low");
                end
                // Slice starts over from its first element
                pos    = 0;
                i_read = 1'b1;
            end
        end while (!o_slice_last && guard < READ_TIMEOUT);
        if (!o_slice_last) begin
            note_timeout("slice_last");
        end
        assert (slice == n_slices)
            else flag_error($sformatf("%0d slices read, expected %0d", slice, n_slices));
        repeat (4) begin
            @(negedge i_clk);
            assert (!o_valid) else flag_error("valid after the last slice");
        end
        i_read = 1'b0;
    endtask

    task automatic terminate_run();
        i_terminate = 1'b1;
        @(negedge i_clk);
        i_terminate = 1'b0;
        assert (!o_convert_done) else flag_error("convert_done high after terminate");
        assert (!o_slice_last) else flag_error("slice_last high after terminate");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Protocol assertions

    assert property (@(posedge i_clk) disable iff (!i_n_reset)
        o_set_param_done == $past(i_set_param, 3))
        else flag_error("set_param_done not 3 cycles after set_param");

    assert property (@(posedge i_clk) disable iff (!i_n_reset)
        o_convert_done && !i_set_param && !i_terminate |=> o_convert_done)
        else flag_error("convert_done dropped on its own");

    assert property (@(posedge i_clk) disable iff (!i_n_reset)
        o_slice_last && !i_set_param && !i_terminate |=> o_slice_last)
        else flag_error("slice_last dropped on its own");

    assert property (@(posedge i_clk) disable iff (!i_n_reset)
        o_slice_last |=> !o_valid)
        else flag_error("valid after slice_last");

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        logic [31:0] rng;
        i_n_reset   = 1'b0;
        i_set_param = 1'b0;
        i_cfg       = '0;
        i_terminate = 1'b0;
        i_enable    = 1'b0;
        i_read      = 1'b0;
        i_data      = '0;
        i_valid     = 1'b0;
        rng = SEED;
        for (int i = 0; i < IMG_DEPTH; i++) begin
            rng      = xorshift32(rng);
            image[i] = rng[DATA_W-1:0] ^ DATA_W'(i);
        end
        conv_cfg = make_cfg(MODE_CONV, 4, 4, 2, 2, 2, 4, 2, 9);
        mvm_cfg  = make_cfg(MODE_MVM, 4, 4, 1, 0, 0, 4, 2, 2);

        repeat (10) @(negedge i_clk);
        i_n_reset = 1'b1;
        @(negedge i_clk);
        assert (!o_set_param_done && !o_convert_done && !o_valid &&
                !o_slice_read_done && !o_slice_last)
            else flag_error("outputs not low after reset");

        configure(conv_cfg);
        build_reference(conv_cfg);
        convert("conv");
        read_out(9, 3, 5);

        configure(mvm_cfg);
        build_reference(mvm_cfg);
        convert("mvm");
        read_out(2, -1, 0);

        terminate_run();
        configure(conv_cfg);
        build_reference(conv_cfg);
        convert("conv again");
        read_out(9, -1, 0);

        repeat (2) @(negedge i_clk);
        $display("Checks finished with %0d value errors and %0d timeouts",
                 error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
src/im2col_pkg.sv
src/im2col_param_regs.sv
src/im2col_addr_gen.sv
src/im2col_col_buffer.sv
src/im2col_slice_reader.sv
src/im2col_top.sv
tb/im2col_tb.sv

// ==== Bender.yml ====
package:
  name: im2col

sources:
  - src/im2col_pkg.sv
  - src/im2col_param_regs.sv
  - src/im2col_addr_gen.sv
  - src/im2col_col_buffer.sv
  - src/im2col_slice_reader.sv
  - src/im2col_top.sv
  - target: simulation
    files:
      - tb/im2col_tb.sv
